/* Bender.yml */
package:
  name: decode_core

sources:
  - design/decode_pkg.sv
  - design/inst_decoder.sv
  - design/reg_file.sv
  - design/id_stage.sv
  - design/id_ex_reg.sv
  - design/decode_core.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_decode_core.sv

/* bench/decode_model.svh */
// decode reference model
// rule-level decode of one instruction into the expected ex_ state,
// plus a shadow copy of the integer register file
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// everything the ID/EX register holds for one instruction
typedef struct packed {
  word_t     ra_value;
  word_t     rb_value;
  reg_idx_t  dest_idx;
  opa_sel_e  opa_select;
  opb_sel_e  opb_select;
  alu_func_e alu_func;
  fu_name_e  fu_name;
  logic      rd_mem, wr_mem, ldl_mem, stc_mem;
  logic      cond_branch, uncond_branch;
  logic      halt, cpuid, illegal, valid_inst;
} ex_state_t;

word_t shadow_regs [0:31];  // mirror of the dut register array

// bubble contents
function automatic ex_state_t noop_state();
  ex_state_t s;
  s = '0;  // operands and all flags clear
  s.dest_idx   = ZERO_REG;
  s.opa_select = OPA_IS_REGA;
  s.opb_select = OPB_IS_REGB;
  s.alu_func   = ALU_ADDQ;
  s.fu_name    = FU_ALU;
  return s;
endfunction

// controls and dest for one word, operand values left at zero
function automatic ex_state_t decode_ref(inst_t w, logic w_valid);
  ex_state_t  s;
  logic [5:0] op;
  logic       bad;
  s   = noop_state();
  op  = w[31:26];
  bad = 1'b0;
  if (w_valid)
  begin
    if (op == INTA_GRP || op == INTL_GRP || op == INTS_GRP || op == INTM_GRP)
    begin
      s.opb_select = w[12] ? OPB_IS_ALU_IMM : OPB_IS_REGB;  // literal form
      s.dest_idx   = w[4:0];
      case ({op, w[11:5]})
        {INTA_GRP, ADDQ_FN}:   s.alu_func = ALU_ADDQ;
        {INTA_GRP, SUBQ_FN}:   s.alu_func = ALU_SUBQ;
        {INTA_GRP, CMPEQ_FN}:  s.alu_func = ALU_CMPEQ;
        {INTA_GRP, CMPLT_FN}:  s.alu_func = ALU_CMPLT;
        {INTA_GRP, CMPLE_FN}:  s.alu_func = ALU_CMPLE;
        {INTA_GRP, CMPULT_FN}: s.alu_func = ALU_CMPULT;
        {INTA_GRP, CMPULE_FN}: s.alu_func = ALU_CMPULE;
        {INTL_GRP, AND_FN}:    s.alu_func = ALU_AND;
        {INTL_GRP, BIC_FN}:    s.alu_func = ALU_BIC;
        {INTL_GRP, BIS_FN}:    s.alu_func = ALU_BIS;
        {INTL_GRP, ORNOT_FN}:  s.alu_func = ALU_ORNOT;
        {INTL_GRP, XOR_FN}:    s.alu_func = ALU_XOR;
        {INTL_GRP, EQV_FN}:    s.alu_func = ALU_EQV;
        {INTS_GRP, SRL_FN}:    s.alu_func = ALU_SRL;
        {INTS_GRP, SLL_FN}:    s.alu_func = ALU_SLL;
        {INTS_GRP, SRA_FN}:    s.alu_func = ALU_SRA;
        {INTM_GRP, MULQ_FN}:
        begin
          s.alu_func = ALU_MULQ;
          s.fu_name  = FU_MULT;
        end
        default: bad = 1'b1;
      endcase
    end
    else if (op == JSR_GRP)
    begin
      s.fu_name       = FU_BR;
      s.opa_select    = OPA_IS_NOT3;
      s.alu_func      = ALU_AND;
      s.dest_idx      = w[25:21];
      s.uncond_branch = 1'b1;
    end
    else if (op == LDA_INST)
    begin
      s.opa_select = OPA_IS_MEM_DISP;
      s.dest_idx   = w[25:21];
    end
    else if (op == LDQ_INST || op == LDQ_L_INST)
    begin
      s.opa_select = OPA_IS_MEM_DISP;
      s.dest_idx   = w[25:21];
      s.fu_name    = FU_LD;
      s.rd_mem     = 1'b1;
      s.ldl_mem    = (op == LDQ_L_INST);
    end
    else if (op == STQ_INST || op == STQ_C_INST)
    begin
      s.opa_select = OPA_IS_MEM_DISP;
      s.fu_name    = FU_ST;
      s.wr_mem     = 1'b1;
      if (op == STQ_C_INST)
      begin
        s.stc_mem  = 1'b1;
        s.dest_idx = w[25:21];  // success flag back to ra
      end
    end
    else if (op[5:4] == 2'b11)  // 0x30 to 0x3f
    begin
      s.opa_select = OPA_IS_NPC;
      s.opb_select = OPB_IS_BR_DISP;
      if (op == BR_INST || op == BSR_INST)
      begin
        s.uncond_branch = 1'b1;
        s.fu_name       = FU_BR;
        s.dest_idx      = w[25:21];
      end
      else if (op == FBEQ_INST || op == FBLT_INST || op == FBLE_INST ||
               op == FBNE_INST || op == FBGE_INST || op == FBGT_INST)
        bad = 1'b1;
      else
        s.cond_branch = 1'b1;
    end
    else if (op == PAL_INST && w[25:0] == PAL_HALT)
      s.halt = 1'b1;
    else if (op == PAL_INST && w[25:0] == PAL_WHAMI)
    begin
      s.cpuid    = 1'b1;
      s.dest_idx = w[25:21];
    end
    else
      bad = 1'b1;
  end
  s.illegal    = bad;
  s.valid_inst = w_valid && !bad;
  return s;
endfunction

// read port with r31 and same-cycle forwarding
function automatic word_t shadow_read(reg_idx_t idx, logic en, reg_idx_t widx, word_t wdata);
  word_t v;
  if (idx == 5'd31)
    v = '0;
  else if (en && widx == idx)
    v = wdata;
  else
    v = shadow_regs[idx];
  return v;
endfunction

// clock edge of the shadow copy
task automatic shadow_update(logic clear, logic en, reg_idx_t widx, word_t wdata);
  if (clear)
  begin
    for (int i = 0; i < 32; i++)
      shadow_regs[i] = '0;
  end
  else if (en && widx != 5'd31)
    shadow_regs[widx] = wdata;
endtask

`endif

/* bench/tb_decode_core.sv */
// testbench for the decode core
// random instruction mix, writeback traffic, stall and flush, all
// compared each cycle against the reference model
`timescale 1ns/1ns

module tb_decode_core;
  import decode_pkg::*;
  `include "decode_model.svh"

  localparam int RESET_CYCLES     = 16;
  localparam int RESET_WAIT_LIMIT = 40;   // cycles
  localparam int RUN_CYCLES       = 4000;

  // opcode and function pairs the decoder knows
  localparam logic [12:0] KNOWN_OPS [0:16] = '{
    {INTA_GRP, ADDQ_FN}, {INTA_GRP, SUBQ_FN}, {INTA_GRP, CMPEQ_FN},
    {INTA_GRP, CMPLT_FN}, {INTA_GRP, CMPLE_FN}, {INTA_GRP, CMPULT_FN},
    {INTA_GRP, CMPULE_FN}, {INTL_GRP, AND_FN}, {INTL_GRP, BIC_FN},
    {INTL_GRP, BIS_FN}, {INTL_GRP, ORNOT_FN}, {INTL_GRP, XOR_FN},
    {INTL_GRP, EQV_FN}, {INTS_GRP, SRL_FN}, {INTS_GRP, SLL_FN},
    {INTS_GRP, SRA_FN}, {INTM_GRP, MULQ_FN}
  };

  //////////////////////////////////////////////////
  // dut signals
  //////////////////////////////////////////////////
  logic      clock = 1'b0;
  logic      rst;
  inst_t     inst;
  logic      inst_valid, stall, flush;
  logic      wb_wr_en;
  reg_idx_t  wb_wr_idx;
  word_t     wb_wr_data;
  word_t     ex_ra_value, ex_rb_value;
  reg_idx_t  ex_dest_idx;
  opa_sel_e  ex_opa_select;
  opb_sel_e  ex_opb_select;
  alu_func_e ex_alu_func;
  fu_name_e  ex_fu_name;
  logic      ex_rd_mem, ex_wr_mem, ex_ldl_mem, ex_stc_mem;
  logic      ex_cond_branch, ex_uncond_branch;
  logic      ex_halt, ex_cpuid, ex_illegal, ex_valid_inst;

  logic [31:0] rng;       // xorshift state
  int          errors;
  int          checks;
  ex_state_t   exp_state;  // expected ex_ outputs

  decode_core u_dut (.*);

  always #5 clock = ~clock;

  function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_val(string name, logic [63:0] expv, logic [63:0] got);
    checks++;
    if (got !== expv)
    begin
      errors++;
      $display("ERROR %s expected %h got %h", name, expv, got);
    end
  endtask

  //////////////////////////////////////////////////
  // model and stimulus
  //////////////////////////////////////////////////

  // next ex_ state from the inputs sampled at this edge
  task automatic model_step();
    ex_state_t nxt;
    if (rst || flush)
      exp_state = noop_state();  // flush wins over stall
    else if (!stall)
    begin
      nxt          = decode_ref(inst, inst_valid);
      nxt.ra_value = shadow_read(inst[25:21], wb_wr_en, wb_wr_idx, wb_wr_data);
      nxt.rb_value = shadow_read(inst[20:16], wb_wr_en, wb_wr_idx, wb_wr_data);
      exp_state    = nxt;
    end
    shadow_update(rst, wb_wr_en, wb_wr_idx, wb_wr_data);
  endtask

  // weighted mix of instruction classes
  task automatic make_inst(output inst_t w);
    int idx;
    rng = xorshift(rng);
    w   = rng;  // random fields underneath
    rng = xorshift(rng);
    idx = rng % 17;
    case (rng[31:28])
      4'd0, 4'd1, 4'd2, 4'd3:
        {w[31:26], w[11:5]} = {KNOWN_OPS[idx][12:7], KNOWN_OPS[idx][6:0]};
      4'd4, 4'd5: w[31:26] = INTA_GRP + rng[5:4];  // random function code
      4'd6:  w[31:26] = LDA_INST;
      4'd7:  w[31:26] = LDQ_INST;
      4'd8:  w[31:26] = LDQ_L_INST;
      4'd9:  w[31:26] = STQ_INST;
      4'd10: w[31:26] = STQ_C_INST;
      4'd11: w[31:26] = JSR_GRP;
      4'd12: w[31:26] = rng[6] ? BR_INST : BSR_INST;
      4'd13: w[31:26] = {2'b11, rng[11:8]};  // cond and fp branches
      4'd14:
      begin
        w[31:26] = PAL_INST;
        if (rng[13:12] == 2'd0)
          w[25:0] = PAL_HALT;
        else if (rng[13:12] == 2'd1)
          w[25:0] = PAL_WHAMI;
      end
      default: ;  // raw random word
    endcase
  endtask

  task automatic drive_random();
    inst_t       w;
    logic [31:0] ctl;
    logic [31:0] hi;
    logic [31:0] lo;
    make_inst(w);
    rng = xorshift(rng);
    ctl = rng;
    rng = xorshift(rng);
    hi  = rng;
    rng = xorshift(rng);
    lo  = rng;
    inst       <= w;
    inst_valid <= (ctl[2:0] != 3'd0);
    stall      <= (ctl[5:3] == 3'd0);
    flush      <= (ctl[9:6] == 4'd0);
    wb_wr_en   <= ctl[10];
    wb_wr_idx  <= ctl[15:11];
    wb_wr_data <= {hi, lo};
  endtask

  task automatic compare_all();
    check_val("ex_ra_value", exp_state.ra_value, ex_ra_value);
    check_val("ex_rb_value", exp_state.rb_value, ex_rb_value);
    check_val("ex_alu_func", exp_state.alu_func, ex_alu_func);
    check_val("ex_fu_name", exp_state.fu_name, ex_fu_name);
    check_val("ex_rd_mem", exp_state.rd_mem, ex_rd_mem);
    check_val("ex_wr_mem", exp_state.wr_mem, ex_wr_mem);
    check_val("ex_ldl_mem", exp_state.ldl_mem, ex_ldl_mem);
    check_val("ex_stc_mem", exp_state.stc_mem, ex_stc_mem);
    check_val("ex_cond_branch", exp_state.cond_branch, ex_cond_branch);
    check_val("ex_uncond_branch", exp_state.uncond_branch, ex_uncond_branch);
    check_val("ex_halt", exp_state.halt, ex_halt);
    check_val("ex_cpuid", exp_state.cpuid, ex_cpuid);
    check_val("ex_illegal", exp_state.illegal, ex_illegal);
    check_val("ex_valid_inst", exp_state.valid_inst, ex_valid_inst);
    check_val("ex_opa_select", exp_state.opa_select, ex_opa_select);
    check_val("ex_opb_select", exp_state.opb_select, ex_opb_select);
    check_val("ex_dest_idx", exp_state.dest_idx, ex_dest_idx);
  endtask

  // bubble straight out of reset
  task automatic check_reset_state();
    check_val("ex_valid_inst", 0, ex_valid_inst);
    check_val("ex_dest_idx", 31, ex_dest_idx);
    check_val("ex_opa_select", OPA_IS_REGA, ex_opa_select);
    check_val("ex_opb_select", OPB_IS_REGB, ex_opb_select);
    check_val("ex_illegal", 0, ex_illegal);
    compare_all();
  endtask

  task automatic run_cycle(logic randomize);
    @(posedge clock);
    model_step();
    if (randomize)
      drive_random();
    @(negedge clock);
    compare_all();
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial
  begin
    int wait_cnt;
    rst        = 1'b1;
    inst       = '0;
    inst_valid = 1'b0;
    stall      = 1'b0;
    flush      = 1'b0;
    wb_wr_en   = 1'b0;
    wb_wr_idx  = '0;
    wb_wr_data = '0;
    rng        = 32'hf22a_5070;
    errors     = 0;
    checks     = 0;
    exp_state  = noop_state();

    repeat (RESET_CYCLES)
    begin
      @(posedge clock);
      model_step();
    end
    rst <= 1'b0;

    wait_cnt = 0;
    while (rst !== 1'b0 && wait_cnt < RESET_WAIT_LIMIT)
    begin
      @(negedge clock);
      wait_cnt++;
    end

    if (rst !== 1'b0)
    begin
      $display("reset was not released within %0d cycles", RESET_WAIT_LIMIT);
      errors++;
    end
    else
    begin
      check_reset_state();
      repeat (4)
        run_cycle(1'b0);  // idle, inst_valid low
      repeat (RUN_CYCLES)
        run_cycle(1'b1);
    end

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

/* design/decode_core.sv */
// decode core
// decode stage followed by the ID/EX register, one cycle from
// instruction in to ex_ controls out
`timescale 1ns/1ns

module decode_core (
  input  logic                  clock,
  input  logic                  rst,
  input  decode_pkg::inst_t     inst,
  input  logic                  inst_valid,
  input  logic                  stall,
  input  logic                  flush,
  input  logic                  wb_wr_en,
  input  decode_pkg::reg_idx_t  wb_wr_idx,
  input  decode_pkg::word_t     wb_wr_data,
  output decode_pkg::word_t     ex_ra_value,
  output decode_pkg::word_t     ex_rb_value,
  output decode_pkg::reg_idx_t  ex_dest_idx,
  output decode_pkg::opa_sel_e  ex_opa_select,
  output decode_pkg::opb_sel_e  ex_opb_select,
  output decode_pkg::alu_func_e ex_alu_func,
  output decode_pkg::fu_name_e  ex_fu_name,
  output logic                  ex_rd_mem, ex_wr_mem, ex_ldl_mem, ex_stc_mem,
  output logic                  ex_cond_branch, ex_uncond_branch,
  output logic                  ex_halt, ex_cpuid, ex_illegal, ex_valid_inst
);
  import decode_pkg::*;

  //////////////////////////////////////////////////
  // id stage outputs, same names as id_ex_reg inputs
  //////////////////////////////////////////////////
  word_t     ra_value;
  word_t     rb_value;
  reg_idx_t  dest_idx;
  opa_sel_e  opa_select;
  opb_sel_e  opb_select;
  alu_func_e alu_func;
  fu_name_e  fu_name;
  logic      rd_mem, wr_mem, ldl_mem, stc_mem;
  logic      cond_branch, uncond_branch;
  logic      halt, cpuid, illegal, valid_inst;

  id_stage u_id_stage (.*);

  id_ex_reg u_id_ex_reg (.*);

endmodule

/* design/decode_pkg.sv */
// decode package
// widths, opcode and function codes, and the control encodings
// that travel from the decode stage into the ID/EX register
package decode_pkg;

  //////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////
  typedef logic [31:0] inst_t;     // one fetched instruction
  typedef logic [63:0] word_t;     // one register value
  typedef logic [4:0]  reg_idx_t;  // register number

  localparam reg_idx_t ZERO_REG = 5'd31;  // always reads 0, also the no-writeback dest

  //////////////////////////////////////////////////
  // control encodings
  //////////////////////////////////////////////////
  typedef enum logic [1:0] {
    OPA_IS_REGA     = 2'h0,
    OPA_IS_MEM_DISP = 2'h1,
    OPA_IS_NPC      = 2'h2,
    OPA_IS_NOT3     = 2'h3   // ~3 mask for jump targets
  } opa_sel_e;

  typedef enum logic [1:0] {
    OPB_IS_REGB    = 2'h0,
    OPB_IS_ALU_IMM = 2'h1,
    OPB_IS_BR_DISP = 2'h2
  } opb_sel_e;

  typedef enum logic [4:0] {
    ALU_ADDQ, ALU_SUBQ,
    ALU_AND, ALU_BIC, ALU_BIS, ALU_ORNOT, ALU_XOR, ALU_EQV,
    ALU_SRL, ALU_SLL, ALU_SRA,
    ALU_MULQ,
    ALU_CMPEQ, ALU_CMPLT, ALU_CMPLE, ALU_CMPULT, ALU_CMPULE
  } alu_func_e;

  typedef enum logic [2:0] {
    FU_ALU, FU_MULT, FU_LD, FU_ST, FU_BR
  } fu_name_e;

  typedef enum logic [1:0] {
    DEST_NONE, DEST_IS_REGA, DEST_IS_REGC
  } dest_sel_e;

  //////////////////////////////////////////////////
  // opcodes, inst[31:26]
  //////////////////////////////////////////////////
  localparam logic [5:0] PAL_INST   = 6'h00;
  localparam logic [5:0] LDA_INST   = 6'h08;
  localparam logic [5:0] INTA_GRP   = 6'h10;  // add, sub, compares
  localparam logic [5:0] INTL_GRP   = 6'h11;  // logicals
  localparam logic [5:0] INTS_GRP   = 6'h12;  // shifts
  localparam logic [5:0] INTM_GRP   = 6'h13;  // multiply
  localparam logic [5:0] JSR_GRP    = 6'h1a;  // jmp, jsr, ret, jsr_co
  localparam logic [5:0] LDQ_INST   = 6'h29;
  localparam logic [5:0] LDQ_L_INST = 6'h2b;
  localparam logic [5:0] STQ_INST   = 6'h2d;
  localparam logic [5:0] STQ_C_INST = 6'h2f;
  localparam logic [5:0] BR_INST    = 6'h30;
  localparam logic [5:0] FBEQ_INST  = 6'h31;
  localparam logic [5:0] FBLT_INST  = 6'h32;
  localparam logic [5:0] FBLE_INST  = 6'h33;
  localparam logic [5:0] BSR_INST   = 6'h34;
  localparam logic [5:0] FBNE_INST  = 6'h35;
  localparam logic [5:0] FBGE_INST  = 6'h36;
  localparam logic [5:0] FBGT_INST  = 6'h37;

  // function codes, inst[11:5]
  localparam logic [6:0] ADDQ_FN   = 7'h20;
  localparam logic [6:0] SUBQ_FN   = 7'h29;
  localparam logic [6:0] CMPEQ_FN  = 7'h2d;
  localparam logic [6:0] CMPLT_FN  = 7'h4d;
  localparam logic [6:0] CMPLE_FN  = 7'h6d;
  localparam logic [6:0] CMPULT_FN = 7'h1d;
  localparam logic [6:0] CMPULE_FN = 7'h3d;
  localparam logic [6:0] AND_FN    = 7'h00;
  localparam logic [6:0] BIC_FN    = 7'h08;
  localparam logic [6:0] BIS_FN    = 7'h20;
  localparam logic [6:0] ORNOT_FN  = 7'h28;
  localparam logic [6:0] XOR_FN    = 7'h40;
  localparam logic [6:0] EQV_FN    = 7'h48;
  localparam logic [6:0] SRL_FN    = 7'h34;
  localparam logic [6:0] SLL_FN    = 7'h39;
  localparam logic [6:0] SRA_FN    = 7'h3c;
  localparam logic [6:0] MULQ_FN   = 7'h20;  // INTM group only

  // pal function field, inst[25:0]
  localparam logic [25:0] PAL_HALT  = 26'h0000;
  localparam logic [25:0] PAL_WHAMI = 26'h003c;

endpackage

/* design/id_ex_reg.sv */
// ID/EX pipeline register
// captures the decoded instruction and its operands; flush loads a
// noop and wins over stall, stall holds every output
`timescale 1ns/1ns

module id_ex_reg (
  input  logic                  clock,
  input  logic                  rst,
  input  logic                  stall,
  input  logic                  flush,
  input  decode_pkg::word_t     ra_value,
  input  decode_pkg::word_t     rb_value,
  input  decode_pkg::reg_idx_t  dest_idx,
  input  decode_pkg::opa_sel_e  opa_select,
  input  decode_pkg::opb_sel_e  opb_select,
  input  decode_pkg::alu_func_e alu_func,
  input  decode_pkg::fu_name_e  fu_name,
  input  logic                  rd_mem, wr_mem, ldl_mem, stc_mem,
  input  logic                  cond_branch, uncond_branch,
  input  logic                  halt, cpuid, illegal, valid_inst,
  output decode_pkg::word_t     ex_ra_value,
  output decode_pkg::word_t     ex_rb_value,
  output decode_pkg::reg_idx_t  ex_dest_idx,
  output decode_pkg::opa_sel_e  ex_opa_select,
  output decode_pkg::opb_sel_e  ex_opb_select,
  output decode_pkg::alu_func_e ex_alu_func,
  output decode_pkg::fu_name_e  ex_fu_name,
  output logic                  ex_rd_mem, ex_wr_mem, ex_ldl_mem, ex_stc_mem,
  output logic                  ex_cond_branch, ex_uncond_branch,
  output logic                  ex_halt, ex_cpuid, ex_illegal, ex_valid_inst
);
  import decode_pkg::*;

  always_ff @(posedge clock)
  begin
    if (rst || flush)
    begin
      // bubble
      ex_ra_value      <= '0;
      ex_rb_value      <= '0;
      ex_dest_idx      <= ZERO_REG;
      ex_opa_select    <= OPA_IS_REGA;
      ex_opb_select    <= OPB_IS_REGB;
      ex_alu_func      <= ALU_ADDQ;
      ex_fu_name       <= FU_ALU;
      ex_rd_mem        <= 1'b0;
      ex_wr_mem        <= 1'b0;
      ex_ldl_mem       <= 1'b0;
      ex_stc_mem       <= 1'b0;
      ex_cond_branch   <= 1'b0;
      ex_uncond_branch <= 1'b0;
      ex_halt          <= 1'b0;
      ex_cpuid         <= 1'b0;
      ex_illegal       <= 1'b0;
      ex_valid_inst    <= 1'b0;
    end
    else if (!stall)  // stalled inst stays, operands not refreshed
    begin
      ex_ra_value      <= ra_value;
      ex_rb_value      <= rb_value;
      ex_dest_idx      <= dest_idx;
      ex_opa_select    <= opa_select;
      ex_opb_select    <= opb_select;
      ex_alu_func      <= alu_func;
      ex_fu_name       <= fu_name;
      ex_rd_mem        <= rd_mem;
      ex_wr_mem        <= wr_mem;
      ex_ldl_mem       <= ldl_mem;
      ex_stc_mem       <= stc_mem;
      ex_cond_branch   <= cond_branch;
      ex_uncond_branch <= uncond_branch;
      ex_halt          <= halt;
      ex_cpuid         <= cpuid;
      ex_illegal       <= illegal;
      ex_valid_inst    <= valid_inst;
    end
  end

endmodule

/* design/id_stage.sv */
// instruction decode stage
// decodes the instruction, reads ra and rb from the register file
// and resolves the writeback register number
`timescale 1ns/1ns

module id_stage (
  input  logic                  clock,
  input  logic                  rst,
  input  decode_pkg::inst_t     inst,
  input  logic                  inst_valid,
  input  logic                  wb_wr_en,    // writeback port
  input  decode_pkg::reg_idx_t  wb_wr_idx,
  input  decode_pkg::word_t     wb_wr_data,
  output decode_pkg::word_t     ra_value,
  output decode_pkg::word_t     rb_value,
  output decode_pkg::reg_idx_t  dest_idx,    // ZERO_REG when nothing written
  output decode_pkg::opa_sel_e  opa_select,
  output decode_pkg::opb_sel_e  opb_select,
  output decode_pkg::alu_func_e alu_func,
  output decode_pkg::fu_name_e  fu_name,
  output logic                  rd_mem, wr_mem, ldl_mem, stc_mem,
  output logic                  cond_branch, uncond_branch,
  output logic                  halt, cpuid,
  output logic                  illegal,
  output logic                  valid_inst
);
  import decode_pkg::*;

  dest_sel_e dest_sel;
  reg_idx_t  ra_idx;
  reg_idx_t  rb_idx;
  reg_idx_t  rc_idx;

  // register fields
  assign ra_idx = inst[25:21];
  assign rb_idx = inst[20:16];
  assign rc_idx = inst[4:0];   // operate format dest

  inst_decoder u_decoder (.*);

  reg_file u_reg_file (
    .clock   (clock),
    .rst     (rst),
    .rda_idx (ra_idx),
    .rdb_idx (rb_idx),
    .wr_en   (wb_wr_en),
    .wr_idx  (wb_wr_idx),
    .wr_data (wb_wr_data),
    .rda_out (ra_value),
    .rdb_out (rb_value)
  );

  // dest select to register number
  always_comb
  begin
    case (dest_sel)
      DEST_IS_REGA: dest_idx = ra_idx;
      DEST_IS_REGC: dest_idx = rc_idx;
      default:      dest_idx = ZERO_REG;
    endcase
  end

endmodule

/* design/inst_decoder.sv */
// instruction decoder
// purely combinational, turns one instruction word into datapath
// control; a low inst_valid gives the noop with valid_inst at 0
`timescale 1ns/1ns

module inst_decoder (
  input  decode_pkg::inst_t     inst,
  input  logic                  inst_valid,
  output decode_pkg::opa_sel_e  opa_select,
  output decode_pkg::opb_sel_e  opb_select,
  output decode_pkg::alu_func_e alu_func,
  output decode_pkg::fu_name_e  fu_name,
  output decode_pkg::dest_sel_e dest_sel,
  output logic                  rd_mem, wr_mem, ldl_mem, stc_mem,
  output logic                  cond_branch, uncond_branch,
  output logic                  halt,
  output logic                  cpuid,
  output logic                  illegal,
  output logic                  valid_inst
);
  import decode_pkg::*;

  logic [5:0] opcode;
  logic [6:0] func;

  assign opcode = inst[31:26];
  assign func   = inst[11:5];

  assign valid_inst = inst_valid && !illegal;  // counts toward retired work

  always_comb
  begin
    // noop defaults, overridden per class below
    opa_select    = OPA_IS_REGA;
    opb_select    = OPB_IS_REGB;
    alu_func      = ALU_ADDQ;
    fu_name       = FU_ALU;
    dest_sel      = DEST_NONE;
    rd_mem        = 1'b0;
    wr_mem        = 1'b0;
    ldl_mem       = 1'b0;
    stc_mem       = 1'b0;
    cond_branch   = 1'b0;
    uncond_branch = 1'b0;
    halt          = 1'b0;
    cpuid         = 1'b0;
    illegal       = 1'b0;

    if (inst_valid)
    begin
      case (opcode[5:3])  // groups of eight opcodes
        3'b000:
        begin
          if (opcode != PAL_INST)
            illegal = 1'b1;
          else if (inst[25:0] == PAL_HALT)
            halt = 1'b1;
          else if (inst[25:0] == PAL_WHAMI)
          begin
            cpuid    = 1'b1;
            dest_sel = DEST_IS_REGA;  // cpu number lands in ra
          end
          else
            illegal = 1'b1;  // other pal calls
        end
        3'b001:
        begin
          if (opcode == LDA_INST)
          begin
            opa_select = OPA_IS_MEM_DISP;  // lda is an add on the alu
            dest_sel   = DEST_IS_REGA;
          end
          else
            illegal = 1'b1;
        end
        3'b010:
        begin
          // operate format, literal when bit 12 set
          opb_select = inst[12] ? OPB_IS_ALU_IMM : OPB_IS_REGB;
          dest_sel   = DEST_IS_REGC;
          case (opcode)
            INTA_GRP:
              case (func)
                ADDQ_FN:   alu_func = ALU_ADDQ;
                SUBQ_FN:   alu_func = ALU_SUBQ;
                CMPEQ_FN:  alu_func = ALU_CMPEQ;
                CMPLT_FN:  alu_func = ALU_CMPLT;
                CMPLE_FN:  alu_func = ALU_CMPLE;
                CMPULT_FN: alu_func = ALU_CMPULT;
                CMPULE_FN: alu_func = ALU_CMPULE;
                default:   illegal  = 1'b1;
              endcase
            INTL_GRP:
              case (func)
                AND_FN:   alu_func = ALU_AND;
                BIC_FN:   alu_func = ALU_BIC;
                BIS_FN:   alu_func = ALU_BIS;
                ORNOT_FN: alu_func = ALU_ORNOT;
                XOR_FN:   alu_func = ALU_XOR;
                EQV_FN:   alu_func = ALU_EQV;
                default:  illegal  = 1'b1;
              endcase
            INTS_GRP:
              case (func)
                SRL_FN:  alu_func = ALU_SRL;
                SLL_FN:  alu_func = ALU_SLL;
                SRA_FN:  alu_func = ALU_SRA;
                default: illegal  = 1'b1;
              endcase
            INTM_GRP:
              if (func == MULQ_FN)
              begin
                alu_func = ALU_MULQ;
                fu_name  = FU_MULT;
              end
              else
                illegal = 1'b1;
            default:
            begin
              opb_select = OPB_IS_REGB;  // fp operate groups stay a noop
              dest_sel   = DEST_NONE;
              illegal    = 1'b1;
            end
          endcase
        end
        3'b011:
        begin
          if (opcode == JSR_GRP)
          begin
            fu_name       = FU_BR;
            opa_select    = OPA_IS_NOT3;
            alu_func      = ALU_AND;  // word-align the target in rb
            dest_sel      = DEST_IS_REGA;  // return address
            uncond_branch = 1'b1;
          end
          else
            illegal = 1'b1;
        end
        3'b101:
        begin
          opa_select = OPA_IS_MEM_DISP;  // base plus displacement
          dest_sel   = DEST_IS_REGA;
          case (opcode)
            LDQ_INST, LDQ_L_INST:
            begin
              rd_mem  = 1'b1;
              ldl_mem = (opcode == LDQ_L_INST);  // lock flag
              fu_name = FU_LD;
            end
            STQ_INST:
            begin
              wr_mem   = 1'b1;
              fu_name  = FU_ST;
              dest_sel = DEST_NONE;
            end
            STQ_C_INST:
            begin
              wr_mem  = 1'b1;
              stc_mem = 1'b1;  // writes success flag back to ra
              fu_name = FU_ST;
            end
            default:
            begin
              opa_select = OPA_IS_REGA;  // longword forms stay a noop
              dest_sel   = DEST_NONE;
              illegal    = 1'b1;
            end
          endcase
        end
        3'b110, 3'b111:
        begin
          opa_select = OPA_IS_NPC;
          opb_select = OPB_IS_BR_DISP;
          case (opcode)
            BR_INST, BSR_INST:
            begin
              uncond_branch = 1'b1;
              fu_name       = FU_BR;
              dest_sel      = DEST_IS_REGA;  // link register
            end
            FBEQ_INST, FBLT_INST, FBLE_INST, FBNE_INST, FBGE_INST, FBGT_INST:
              illegal = 1'b1;  // no fp unit
            default: cond_branch = 1'b1;  // integer test on ra
          endcase
        end
        default: illegal = 1'b1;  // fp loads and stores
      endcase
    end
  end

endmodule

/* design/reg_file.sv */
// integer register file
// 32 x 64 bits, two combinational read ports and one write port;
// a same-cycle write is forwarded to the readers, r31 reads zero
`timescale 1ns/1ns

module reg_file (
  input  logic                 clock,
  input  logic                 rst,
  input  decode_pkg::reg_idx_t rda_idx,
  input  decode_pkg::reg_idx_t rdb_idx,
  input  logic                 wr_en,
  input  decode_pkg::reg_idx_t wr_idx,
  input  decode_pkg::word_t    wr_data,
  output decode_pkg::word_t    rda_out,
  output decode_pkg::word_t    rdb_out
);
  import decode_pkg::*;

  word_t regs [0:31];  // entry 31 never written

  // one read port with zero reg and write-through
  function automatic word_t read_port(reg_idx_t idx);
    word_t val;
    if (idx == ZERO_REG)
      val = '0;
    else if (wr_en && (wr_idx == idx))
      val = wr_data;  // bypass the array
    else
      val = regs[idx];
    return val;
  endfunction

  always_comb rda_out = read_port(rda_idx);
  always_comb rdb_out = read_port(rdb_idx);

  always_ff @(posedge clock)
  begin
    if (rst)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (wr_en && (wr_idx != ZERO_REG))
      regs[wr_idx] <= wr_data;
  end

endmodule

/* sources.f */
+incdir+bench
design/decode_pkg.sv
design/inst_decoder.sv
design/reg_file.sv
design/id_stage.sv
design/id_ex_reg.sv
design/decode_core.sv
bench/tb_decode_core.sv
